// File: Makefile
# Verilator build and run for the RV32I ALU core

VERILATOR ?= verilator
TOP ?= tb_rv_alu_core
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "FAIL: pass line missing from $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
verilog/rv_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/rv_alu_core.sv
tests/rv_alu_core_asserts.sv
tests/tb_rv_alu_core.sv

// File: tests/rv_alu_core_asserts.sv
`timescale 1ns/100ps

module rv_alu_core_asserts
	import rv_isa_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic inst_valid,
	input logic wb_valid,
	input logic wb_illegal,
	input reg_idx_t wb_rd
);

	// A retire is a write or an illegal flag, never both
	write_or_illegal: assert property (@(posedge CLK) disable iff (!rst_n)
		!(wb_valid && wb_illegal))
		else $error("wb_valid and wb_illegal high together");

	// x0 writes drop out in execute
	no_x0_write: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid |-> (wb_rd != '0))
		else $error("wb_valid with wb_rd zero");

	// Fixed latency of two edges from issue
	retire_latency: assert property (@(posedge CLK) disable iff (!rst_n)
		(wb_valid || wb_illegal) |-> $past(inst_valid, 2))
		else $error("retire pulse without an instruction two cycles earlier");

endmodule

bind rv_alu_core rv_alu_core_asserts port_checks (
	.CLK(CLK),
	.rst_n(rst_n),
	.inst_valid(inst_valid),
	.wb_valid(wb_valid),
	.wb_illegal(wb_illegal),
	.wb_rd(wb_rd)
);

// File: tests/rv_alu_core_patterns.txt
# inst(hex) wb_valid wb_illegal wb_rd(dec) wb_data(hex) test_name
# wb_rd and wb_data are compared only where wb_valid is expected high
0020e0b3 1 0 1 00000000 reset_read_x1_x2
0041e1b3 1 0 3 00000000 reset_read_x3_x4
0062e2b3 1 0 5 00000000 reset_read_x5_x6
0083e3b3 1 0 7 00000000 reset_read_x7_x8
00a4e4b3 1 0 9 00000000 reset_read_x9_x10
00c5e5b3 1 0 11 00000000 reset_read_x11_x12
00e6e6b3 1 0 13 00000000 reset_read_x13_x14
0107e7b3 1 0 15 00000000 reset_read_x15_x16
0128e8b3 1 0 17 00000000 reset_read_x17_x18
0149e9b3 1 0 19 00000000 reset_read_x19_x20
016aeab3 1 0 21 00000000 reset_read_x21_x22
018bebb3 1 0 23 00000000 reset_read_x23_x24
01acecb3 1 0 25 00000000 reset_read_x25_x26
01cdedb3 1 0 27 00000000 reset_read_x27_x28
01eeeeb3 1 0 29 00000000 reset_read_x29_x30
000fefb3 1 0 31 00000000 reset_read_x31_x0
ffb00093 1 0 1 fffffffb addi_neg_imm
06400113 1 0 2 00000064 addi_pos_imm
0010a193 1 0 3 00000001 slti_signed_true
0010b213 1 0 4 00000000 sltiu_unsigned_false
fff14293 1 0 5 ffffff9b xori_all_ones
70016313 1 0 6 00000764 ori
0f00f393 1 0 7 000000f0 andi
00411413 1 0 8 00000640 slli
01c0d493 1 0 9 0000000f srli_neg_value
4010d513 1 0 10 fffffffd srai_neg_value
800015b7 1 0 11 80001000 lui
00208633 1 0 12 0000005f add
402086b3 1 0 13 ffffff97 sub
00111733 1 0 14 20000000 sll_low_five_bits
0020a7b3 1 0 15 00000001 slt_true
0020b833 1 0 16 00000000 sltu_false
00b0c8b3 1 0 17 7fffeffb xor
0035d933 1 0 18 40000800 srl
4035d9b3 1 0 19 c0000800 sra_neg_value
00b16a33 1 0 20 80001064 or
00b0fab3 1 0 21 80001000 and
00112b33 1 0 22 00000000 slt_false
00113bb3 1 0 23 00000001 sltu_true
00700c13 1 0 24 00000007 chain_seed
018c0c33 1 0 24 0000000e chain_double
401c0cb3 1 0 25 00000013 chain_sub
018c8d33 1 0 26 00000021 chain_add
019d4c33 1 0 24 00000032 chain_xor
01ac0db3 1 0 27 00000053 chain_sum
00508013 0 0 0 00000000 x0_write_dropped
00200e33 1 0 28 00000064 x0_reads_zero
0000ae83 0 1 0 00000000 illegal_load_opcode
40109e93 0 1 0 00000000 illegal_slli_funct7
002e8f33 1 0 30 00000064 illegal_left_x29_zero

// File: tests/tb_rv_alu_core.sv
`timescale 1ns/100ps

module tb_rv_alu_core
	import rv_isa_pkg::*;
();

	localparam int CLK_PERIOD = 10;		// ns
	localparam int RESET_CYCLES = 5;
	localparam int unsigned RAND_SEED = 32'h35e5cd84;
	localparam string PATTERN_FILE = "tests/rv_alu_core_patterns.txt";

	// One pattern line with its expected retire values
	typedef struct packed {
		inst_t inst;
		logic exp_valid;
		logic exp_illegal;
		reg_idx_t exp_rd;
		word_t exp_data;
	} pattern_t;

	// One driven cycle that is idle or issues pattern idx
	typedef struct packed {
		logic issued;
		int unsigned idx;
	} slot_t;

	logic CLK;
	logic rst_n;
	logic inst_valid;
	inst_t inst;
	logic wb_valid;
	logic wb_illegal;
	reg_idx_t wb_rd;
	word_t wb_data;

	pattern_t pats[$];
	string names[$];				// Test name per pattern line
	slot_t slots[$];				// Driven cycles waiting for their retire check
	int unsigned issued_count = 0;
	int unsigned checked_count = 0;
	logic pats_loaded = 1'b0;

	rv_alu_core UUT (
		.CLK(CLK),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.wb_valid(wb_valid),
		.wb_illegal(wb_illegal),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic load_patterns();
		int fd;
		int status;
		string line;
		string name;
		inst_t f_inst;
		word_t f_data;
		int unsigned f_valid, f_illegal, f_rd;
		pattern_t p;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open pattern file %s", PATTERN_FILE);
			$display("Verification failed");
			$fatal(1);
		end else begin
			while (!$feof(fd)) begin
				status = $fgets(line, fd);
				// Header and blank lines do not scan to six fields
				if (status > 0 && $sscanf(line, "%h %d %d %d %h %s", f_inst, f_valid,
						f_illegal, f_rd, f_data, name) == 6) begin
					p.inst = f_inst;
					p.exp_valid = f_valid[0];
					p.exp_illegal = f_illegal[0];
					p.exp_rd = f_rd[REG_IDX_W-1:0];
					p.exp_data = f_data;
					pats.push_back(p);
					names.push_back(name);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_value(input string test_name, input string field,
			input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("** Error: %s %s expected %h, actual %h at %0t", test_name, field,
				expected, actual, $time);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// Retire ports against one pattern line
	task automatic check_retire(input int unsigned idx);
		pattern_t p;
		p = pats[idx];
		check_value(names[idx], "wb_valid", word_t'(p.exp_valid), word_t'(wb_valid));
		check_value(names[idx], "wb_illegal", word_t'(p.exp_illegal), word_t'(wb_illegal));
		if (p.exp_valid) begin		// rd and data only mean something on a write
			check_value(names[idx], "wb_rd", word_t'(p.exp_rd), word_t'(wb_rd));
			check_value(names[idx], "wb_data", p.exp_data, wb_data);
		end
	endtask

	task automatic check_quiet();
		if (wb_valid || wb_illegal) begin
			$display("Unexpected retire pulse at %0t with no instruction due", $time);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// Drive one cycle and move to 1 ns after the next rising edge
	task automatic issue_cycle(input logic valid, input inst_t word, input int unsigned idx);
		slot_t s;
		s.issued = valid;
		s.idx = idx;
		inst_valid = valid;
		inst = word;
		slots.push_back(s);
		@(posedge CLK);
		#1;
	endtask

	// Slot driven two edges back is on the ports now
	always @(negedge CLK) begin
		slot_t s;
		if (rst_n) begin
			if (slots.size() > 2) begin
				s = slots.pop_front();
				if (s.issued) begin
					check_retire(s.idx);
					checked_count++;
				end else begin
					check_quiet();
				end
			end else begin
				check_quiet();		// Only reset or idle cycles behind us
			end
		end
	end

	initial begin
		int unsigned gap;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		void'($urandom(RAND_SEED));
		load_patterns();
		pats_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		for (int unsigned i = 0; i < pats.size(); i++) begin
			issued_count++;
			issue_cycle(1'b1, pats[i].inst, i);
			gap = $urandom % 3;		// Random gap varies the forwarding distance
			repeat (gap) issue_cycle(1'b0, '0, 0);
		end
		while (checked_count < issued_count)
			issue_cycle(1'b0, '0, 0);	// Drain the pipeline
		if (issued_count != 0 && checked_count == issued_count) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1);
		end
	end

	// Watchdog
	initial begin
		int limit_cycles;
		wait (pats_loaded);
		limit_cycles = pats.size() * 5 + 20;
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout after %0d cycles before every instruction retired", limit_cycles);
		$display("Verification failed");
		$fatal(1);
	end

endmodule

// File: verilog/core_pipe_pkg.sv
package core_pipe_pkg;

	import rv_isa_pkg::*;

	// ALU operation select
	// Encoding is local to this core, 4 bits wide
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_SLL = 4'd2,
		ALU_SLT = 4'd3,		// Signed less than, result 0 or 1
		ALU_SLTU = 4'd4,	// Unsigned less than
		ALU_XOR = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SRA = 4'd7,		// Sign fills from the left
		ALU_OR = 4'd8,
		ALU_AND = 4'd9,
		ALU_PASS_B = 4'd10	// LUI, immediate goes straight through
	} alu_op_e;

	// Decode to execute packet
	// Operands are already forwarded and immediate is already in op_b
	typedef struct packed {
		logic valid;		// Legal instruction present
		logic illegal;		// Unsupported encoding, no write
		alu_op_e alu_op;
		reg_idx_t rd;
		word_t op_a;
		word_t op_b;
	} exe_op_t;

	// Execute to result packet
	typedef struct packed {
		logic valid;		// Register write, never set for x0
		logic illegal;
		reg_idx_t rd;
		word_t data;		// ALU result
	} retire_t;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
	import rv_isa_pkg::*, core_pipe_pkg::*;
(
	input logic CLK,
	input logic rst_n,

	input logic inst_valid,		// One instruction per high cycle
	input inst_t inst,

	// Register file read
	output reg_idx_t rs1_idx,
	output reg_idx_t rs2_idx,
	input word_t rs1_data,		// Already bypassed against a same-cycle write
	input word_t rs2_data,

	// Forwarding from later stages
	input word_t ex_fwd_data,	// ALU result of the packet held in exe_pkt
	input retire_t res_pkt,		// Older instruction, one stage further on

	output exe_op_t exe_pkt
);

	// Instruction fields
	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	reg_idx_t rd;

	// Immediates
	word_t imm_i;		// Sign extended inst[31:20]
	word_t imm_u;		// inst[31:12] in the upper bits

	// Control
	alu_op_e alu_op;
	logic legal;
	logic use_imm;		// op_b comes from the immediate
	logic alt_op;		// funct7 selects SUB or SRA
	word_t imm;

	// Resolved operands
	word_t fwd_a, fwd_b;
	exe_op_t exe_next;

	assign opcode = inst[6:0];
	assign rd = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1_idx = inst[19:15];
	assign rs2_idx = inst[24:20];
	assign funct7 = inst[31:25];

	assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};

	// Bit 30 on ADDI belongs to the immediate, so it only counts for OP or shifts
	assign alt_op = (funct7 == F7_ALT) && (opcode == OPC_OP || funct3 == F3_SR);

	// funct3 to ALU operation, shared by OP and OP-IMM
	function automatic alu_op_e f3_to_op(funct3_t f3, logic alt);
		alu_op_e op;
		case (f3)
			F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL: op = ALU_SLL;
			F3_SLT: op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR: op = ALU_XOR;
			F3_SR: op = alt ? ALU_SRA : ALU_SRL;
			F3_OR: op = ALU_OR;
			default: op = ALU_AND;		// F3_AND
		endcase
		return op;
	endfunction

	// Control decode
	always_comb begin
		alu_op = f3_to_op(funct3, alt_op);
		legal = 1'b1;
		use_imm = 1'b0;
		imm = imm_i;
		case (opcode)
			OPC_LUI: begin
				alu_op = ALU_PASS_B;
				use_imm = 1'b1;
				imm = imm_u;
			end
			OPC_OP_IMM: begin
				use_imm = 1'b1;
				if (funct3 == F3_SLL)
					legal = (funct7 == F7_BASE);	// SLLI takes no funct7
				else if (funct3 == F3_SR)
					legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);	// SRLI or SRAI
			end
			OPC_OP: begin
				// Alternate funct7 only exists for SUB and SRA
				legal = (funct7 == F7_BASE) ||
					(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
			end
			default: legal = 1'b0;		// Loads, stores, branches and the rest
		endcase
	end

	// Operand resolution, youngest producer wins
	function automatic word_t resolve(reg_idx_t idx, word_t rf_word, exe_op_t ex,
			word_t ex_data, retire_t rs);
		word_t val;
		if (idx == '0)
			val = '0;			// x0 is never forwarded
		else if (ex.valid && ex.rd == idx)
			val = ex_data;		// Instruction now in execute
		else if (rs.valid && rs.rd == idx)
			val = rs.data;		// Instruction in result stage
		else
			val = rf_word;
		return val;
	endfunction

	assign fwd_a = resolve(rs1_idx, rs1_data, exe_pkt, ex_fwd_data, res_pkt);
	assign fwd_b = resolve(rs2_idx, rs2_data, exe_pkt, ex_fwd_data, res_pkt);

	// Next packet
	always_comb begin
		exe_next.valid = inst_valid & legal;
		exe_next.illegal = inst_valid & ~legal;
		exe_next.alu_op = alu_op;
		exe_next.rd = rd;
		exe_next.op_a = fwd_a;
		exe_next.op_b = use_imm ? imm : fwd_b;
	end

	// Decode pipeline register, idle cycles become invalid packets
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			exe_pkt <= '0;
		else
			exe_pkt <= exe_next;
	end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/100ps

module execute_stage
	import rv_isa_pkg::*, core_pipe_pkg::*;
(
	input logic CLK,
	input logic rst_n,

	input exe_op_t exe_pkt,		// From decode register

	output word_t ex_fwd_data,	// Back to decode, same cycle
	output retire_t res_pkt
);

	word_t op_a, op_b;
	word_t alu_res;
	logic [SHAMT_W-1:0] shamt;	// Low bits of operand B only
	retire_t res_next;

	assign op_a = exe_pkt.op_a;
	assign op_b = exe_pkt.op_b;
	assign shamt = op_b[SHAMT_W-1:0];

	// ALU
	always_comb begin
		case (exe_pkt.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_SLL: alu_res = op_a << shamt;
			ALU_SLT: alu_res = word_t'($signed(op_a) < $signed(op_b));	// 1 or 0
			ALU_SLTU: alu_res = word_t'(op_a < op_b);
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_SRL: alu_res = op_a >> shamt;
			ALU_SRA: alu_res = word_t'($signed(op_a) >>> shamt);
			ALU_OR: alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;		// LUI
			default: alu_res = '0;			// Unused encodings
		endcase
	end

	// Forwarded straight out; decode owns the matching rd and valid
	assign ex_fwd_data = alu_res;

	// Retire packet
	always_comb begin
		res_next.valid = exe_pkt.valid && (exe_pkt.rd != '0);	// x0 write drops here
		res_next.illegal = exe_pkt.illegal;
		res_next.rd = exe_pkt.rd;
		res_next.data = alu_res;
	end

	// Execute pipeline register
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			res_pkt <= '0;
		else
			res_pkt <= res_next;
	end

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/100ps

module result_stage
	import rv_isa_pkg::*, core_pipe_pkg::*;
(
	input logic CLK,
	input logic rst_n,

	input retire_t res_pkt,		// Write request, valid only for rd != 0

	// Read ports for decode
	input reg_idx_t rs1_idx,
	input reg_idx_t rs2_idx,
	output word_t rs1_data,
	output word_t rs2_data,

	// Retire ports
	output logic wb_valid,
	output logic wb_illegal,
	output reg_idx_t wb_rd,
	output word_t wb_data
);

	// x1 to x31, x0 has no storage
	word_t regs [1:NUM_REGS-1];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (res_pkt.valid) begin
			regs[res_pkt.rd] <= res_pkt.data;
		end
	end

	// Reads see a write landing at the same edge
	assign rs1_data = (rs1_idx == '0) ? '0 :
		(res_pkt.valid && res_pkt.rd == rs1_idx) ? res_pkt.data : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 :
		(res_pkt.valid && res_pkt.rd == rs2_idx) ? res_pkt.data : regs[rs2_idx];

	// Packet goes out as is
	assign wb_valid = res_pkt.valid;		// One pulse per write
	assign wb_illegal = res_pkt.illegal;
	assign wb_rd = res_pkt.rd;
	assign wb_data = res_pkt.data;

endmodule

// File: verilog/rv_alu_core.sv
`timescale 1ns/100ps

module rv_alu_core
	import rv_isa_pkg::*, core_pipe_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic inst_valid,		// Plain strobe, no back-pressure
	input inst_t inst,
	output logic wb_valid,		// Two cycles after issue
	output logic wb_illegal,
	output reg_idx_t wb_rd,
	output word_t wb_data
);

	exe_op_t exe_pkt;			// Decode to execute
	retire_t res_pkt;			// Execute to result, also forwarded
	word_t ex_fwd_data;			// Execute result back to decode
	reg_idx_t rs1_idx, rs2_idx;
	word_t rs1_data, rs2_data;

	decode_stage decode (.*);
	execute_stage execute (.*);
	result_stage result (.*);

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	// Base integer ISA widths
	localparam int XLEN = 32;				// Data path width
	localparam int ILEN = 32;				// No compressed forms, every instruction is one word
	localparam int NUM_REGS = 32;			// x0 to x31, x0 hardwired
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int SHAMT_W = 5;				// Shift amount bits used out of operand B

	// Meaningful widths
	typedef logic [XLEN-1:0] word_t;		// Register and ALU word
	typedef logic [ILEN-1:0] inst_t;		// Raw instruction
	typedef logic [REG_IDX_W-1:0] reg_idx_t;	// rs1, rs2, rd
	typedef logic [6:0] opcode_t;			// inst[6:0]
	typedef logic [2:0] funct3_t;			// inst[14:12]
	typedef logic [6:0] funct7_t;			// inst[31:25]

	// Major opcodes carried by this core
	// Anything else is flagged illegal in decode
	localparam opcode_t OPC_OP = 7'b0110011;		// R-type register-register
	localparam opcode_t OPC_OP_IMM = 7'b0010011;	// I-type register-immediate
	localparam opcode_t OPC_LUI = 7'b0110111;		// U-type load upper immediate

	// funct3 encodings
	// Same values for OP and OP-IMM
	localparam funct3_t F3_ADD_SUB = 3'b000;	// ADD, SUB, ADDI
	localparam funct3_t F3_SLL = 3'b001;		// SLL, SLLI
	localparam funct3_t F3_SLT = 3'b010;		// Signed compare
	localparam funct3_t F3_SLTU = 3'b011;		// Unsigned compare
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_SR = 3'b101;		// SRL/SRA and immediate forms
	localparam funct3_t F3_OR = 3'b110;
	localparam funct3_t F3_AND = 3'b111;

	// funct7 encodings
	// Bit 30 picks the alternate operation
	localparam funct7_t F7_BASE = 7'b0000000;	// ADD, SRL and the rest
	localparam funct7_t F7_ALT = 7'b0100000;	// SUB and SRA only

endpackage
